/* common/capture_pkg.sv */
package capture_pkg;

    // one adc conversion result
    typedef logic [11:0] sample_t;

    typedef logic [12:0] ds_count_t;   // stride counter width
    typedef logic [15:0] count_t;      // sample counts

    // capture setup, held stable while armed
    typedef struct packed {
        count_t    presample;    // samples kept from before the trigger
        count_t    max_samples;  // requested total, rounded up in the fsm
        ds_count_t downsample;   // samples skipped between kept ones
    } capture_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_e;

    localparam int SAMPLES_PER_WORD  = 3;
    localparam int SAMPLES_PER_ROUND = 6;  // two words, one full hi-res byte cycle

endpackage

/* common/readout_pkg.sv */
package readout_pkg;

    // three 12-bit samples, oldest in bits 35:24
    typedef logic [35:0] packed_word_t;

    typedef enum logic {
        LOW_RES,   // top 8 bits per sample
        HIGH_RES   // full 12 bits, 9 bytes per word pair
    } read_mode_e;

    // position within the 9-byte cycle
    typedef logic [3:0] byte_idx_t;

    // last byte of a word in low-res mode
    localparam byte_idx_t LOW_RES_LAST = 4'd2;

    // hi-res pops after byte 3 (first word) and byte 8 (second word)
    localparam byte_idx_t HIGH_RES_MID  = 4'd3;
    localparam byte_idx_t HIGH_RES_LAST = 4'd8;

endpackage

/* hw/downsampler.sv */
module downsampler
    import capture_pkg::*;
(
    input  logic      adc_sampleclk,
    input  logic      reset,
    input  logic      restart_i,   // realigns the stride to the arm point
    input  ds_count_t ds_ratio_i,
    output logic      keep_o
);

    ds_count_t cnt;

    // plain stride pick, no filtering
    always_ff @(posedge adc_sampleclk) begin
        if (reset || restart_i) begin
            cnt    <= '0;
            keep_o <= 1'b0;
        end else if (cnt == ds_ratio_i) begin
            cnt    <= '0;
            keep_o <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            keep_o <= 1'b0;
        end
    end

endmodule

/* hw/sample_fifo.sv */
module sample_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 64
) (
    input  logic     adc_sampleclk,
    input  logic     reset,
    input  logic     wr_i,
    input  payload_t data_i,
    input  logic     rd_i,
    output payload_t data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic       do_wr;
    logic       do_rd;

    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);
    assign do_wr   = wr_i && !full_o;
    assign do_rd   = rd_i && !empty_o;
    assign data_o  = mem[rd_ptr];  // head shows without a read

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

endmodule

/* capture/capture_fsm.sv */
module capture_fsm
    import capture_pkg::*;
(
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  logic         arm_i,
    input  logic         capture_go_i,
    input  capture_cfg_t cfg_i,
    input  logic         sample_keep_i,
    input  logic         fast_full_i,
    input  logic         fast_empty_i,
    output logic         arm_start_o,
    output logic         fast_wr_o,
    output logic         presample_drain_o,
    output logic         transfer_en_o,
    output logic         capture_done_o
);

    capture_state_e state;
    logic           arm_q;
    logic           arm_edge;
    logic           writing;
    count_t         pre_cnt;      // samples sitting in the fast fifo before trigger
    count_t         sample_cnt;   // total written this capture
    count_t         pre_cnt_next;
    count_t         sample_cnt_next;
    count_t         target;
    logic [16:0]    round_up;

    assign arm_edge    = arm_i & ~arm_q;
    assign arm_start_o = arm_edge && (state == IDLE);  // downsampler restarts with the fsm

    assign writing = (state == PRESAMP_FILLING) || (state == PRESAMP_FULL)
                     || (state == TRIGGERED);
    assign fast_wr_o = sample_keep_i && writing && !fast_full_i;

    // once the window is full every new sample pushes the oldest one out
    assign presample_drain_o = fast_wr_o && (state == PRESAMP_FULL);

    assign transfer_en_o = (state == TRIGGERED) || (state == DONE);

    // hi-res readout needs whole word pairs
    assign round_up = 17'(cfg_i.max_samples) + 17'(SAMPLES_PER_ROUND - 1);
    assign target   = count_t'((round_up / 17'(SAMPLES_PER_ROUND)) * 17'(SAMPLES_PER_ROUND));

    assign pre_cnt_next    = pre_cnt + count_t'(fast_wr_o);
    assign sample_cnt_next = sample_cnt + count_t'(fast_wr_o);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state          <= IDLE;
            arm_q          <= 1'b0;
            pre_cnt        <= '0;
            sample_cnt     <= '0;
            capture_done_o <= 1'b0;
        end else begin
            arm_q <= arm_i;
            case (state)
                IDLE: begin
                    pre_cnt    <= '0;
                    sample_cnt <= '0;
                    if (arm_edge) begin
                        capture_done_o <= 1'b0;
                        state <= (cfg_i.presample != '0) ? PRESAMP_FILLING : TRIGGERED;
                    end
                end
                PRESAMP_FILLING: begin
                    pre_cnt <= pre_cnt_next;
                    if (capture_go_i) begin  // early trigger, short window
                        sample_cnt <= pre_cnt_next;
                        state      <= TRIGGERED;
                    end else if (pre_cnt_next == cfg_i.presample) begin
                        state <= PRESAMP_FULL;
                    end
                end
                PRESAMP_FULL: begin
                    if (capture_go_i) begin
                        sample_cnt <= cfg_i.presample;
                        state      <= TRIGGERED;
                    end
                end
                TRIGGERED: begin
                    sample_cnt <= sample_cnt_next;
                    if (sample_cnt_next >= target)
                        state <= DONE;
                end
                DONE: begin
                    // let the packer empty the fast fifo first
                    if (fast_empty_i) begin
                        capture_done_o <= 1'b1;
                        state          <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* capture/sample_packer.sv */
module sample_packer
    import capture_pkg::*;
    import readout_pkg::*;
(
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  logic         transfer_en_i,
    input  logic         fast_empty_i,
    input  sample_t      fast_data_i,
    input  logic         slow_full_i,
    output logic         fast_rd_o,
    output packed_word_t word_o,
    output logic         word_wr_o
);

    logic [1:0]   rd_cnt;   // 0..2 within the current word
    packed_word_t shift_q;

    assign fast_rd_o = transfer_en_i && !fast_empty_i && !slow_full_i;
    assign word_o    = shift_q;

    // oldest sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (fast_rd_o)
            shift_q <= {shift_q[23:0], fast_data_i};
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            rd_cnt    <= '0;
            word_wr_o <= 1'b0;
        end else begin
            word_wr_o <= 1'b0;
            if (fast_rd_o) begin
                if (rd_cnt == 2'(SAMPLES_PER_WORD - 1)) begin
                    rd_cnt    <= '0;
                    word_wr_o <= 1'b1;  // lands with the third sample
                end else begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* readout/byte_reader.sv */
module byte_reader
    import readout_pkg::*;
(
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  read_mode_e   read_mode_i,
    input  logic         read_en_i,
    input  packed_word_t word_i,
    input  logic         empty_i,
    output logic         pop_o,
    output logic [7:0]   byte_o
);

    byte_idx_t  idx;
    logic [3:0] nibble_q;   // tail of the first word, goes out in byte 4
    logic       advance;
    logic       wrap;

    assign advance = read_en_i && !empty_i;
    assign wrap    = (read_mode_i == HIGH_RES) ? (idx == HIGH_RES_LAST) : (idx == LOW_RES_LAST);
    assign pop_o   = advance && (wrap || (read_mode_i == HIGH_RES && idx == HIGH_RES_MID));

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            idx <= '0;
        else if (advance)
            idx <= wrap ? '0 : idx + 1'b1;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (advance && idx == HIGH_RES_MID)
            nibble_q <= word_i[3:0];
    end

    always_comb begin
        byte_o = 8'h00;
        if (read_mode_i == LOW_RES) begin
            case (idx)
                4'd0: byte_o = word_i[35:28];
                4'd1: byte_o = word_i[23:16];
                4'd2: byte_o = word_i[11:4];
                default: byte_o = 8'h00;
            endcase
        end else begin
            case (idx)
                4'd0: byte_o = word_i[35:28];
                4'd1: byte_o = word_i[27:20];
                4'd2: byte_o = word_i[19:12];
                4'd3: byte_o = word_i[11:4];
                4'd4: byte_o = {nibble_q, word_i[35:32]};  // straddles both words
                4'd5: byte_o = word_i[31:24];
                4'd6: byte_o = word_i[23:16];
                4'd7: byte_o = word_i[15:8];
                4'd8: byte_o = word_i[7:0];
                default: byte_o = 8'h00;
            endcase
        end
    end

endmodule

/* hw/fifo_capture_top.sv */
module fifo_capture_top
    import capture_pkg::*;
    import readout_pkg::*;
#(
    parameter int FAST_DEPTH = 64,
    parameter int SLOW_DEPTH = 64
) (
    input  logic         reset,
    input  logic         adc_sampleclk,
    input  sample_t      adc_data_i,
    input  logic         arm_i,
    input  logic         capture_go_i,
    input  capture_cfg_t cfg_i,
    input  read_mode_e   read_mode_i,
    input  logic         read_en_i,
    output logic         capture_done_o,
    output logic         fifo_empty_o,
    output logic [7:0]   read_data_o
);

    logic         arm_start;
    logic         sample_keep;
    logic         fast_wr;
    logic         fast_rd;
    logic         presample_drain;
    logic         packer_rd;
    logic         transfer_en;
    logic         fast_full;
    logic         fast_empty;
    sample_t      fast_data;
    packed_word_t word_in;
    packed_word_t word_out;
    logic         word_wr;
    logic         word_pop;
    logic         slow_full;

    // drain only runs before the trigger, packer reads only after
    assign fast_rd = presample_drain | packer_rd;

    downsampler u_downsampler (
        .adc_sampleclk(adc_sampleclk), .reset(reset), .restart_i(arm_start),
        .ds_ratio_i(cfg_i.downsample), .keep_o(sample_keep)
    );

    capture_fsm u_capture_fsm (
        .adc_sampleclk(adc_sampleclk), .reset(reset), .arm_i(arm_i),
        .capture_go_i(capture_go_i), .cfg_i(cfg_i), .sample_keep_i(sample_keep),
        .fast_full_i(fast_full), .fast_empty_i(fast_empty), .arm_start_o(arm_start),
        .fast_wr_o(fast_wr), .presample_drain_o(presample_drain),
        .transfer_en_o(transfer_en), .capture_done_o(capture_done_o)
    );

    sample_fifo #(.payload_t(sample_t), .DEPTH(FAST_DEPTH)) u_fast_fifo (
        .adc_sampleclk(adc_sampleclk), .reset(reset), .wr_i(fast_wr), .data_i(adc_data_i),
        .rd_i(fast_rd), .data_o(fast_data), .full_o(fast_full), .empty_o(fast_empty)
    );

    sample_packer u_sample_packer (
        .adc_sampleclk(adc_sampleclk), .reset(reset), .transfer_en_i(transfer_en),
        .fast_empty_i(fast_empty), .fast_data_i(fast_data), .slow_full_i(slow_full),
        .fast_rd_o(packer_rd), .word_o(word_in), .word_wr_o(word_wr)
    );

    sample_fifo #(.payload_t(packed_word_t), .DEPTH(SLOW_DEPTH)) u_slow_fifo (
        .adc_sampleclk(adc_sampleclk), .reset(reset), .wr_i(word_wr), .data_i(word_in),
        .rd_i(word_pop), .data_o(word_out), .full_o(slow_full), .empty_o(fifo_empty_o)
    );

    byte_reader u_byte_reader (
        .adc_sampleclk(adc_sampleclk), .reset(reset), .read_mode_i(read_mode_i),
        .read_en_i(read_en_i), .word_i(word_out), .empty_i(fifo_empty_o),
        .pop_o(word_pop), .byte_o(read_data_o)
    );

endmodule

/* bench/capture_model.svh */
`ifndef CAPTURE_MODEL_SVH
`define CAPTURE_MODEL_SVH

// xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic int round_to_six(input int n);
    int r;
    r = n;
    while (r % 6 != 0)
        r++;  // whole word pairs only
    return r;
endfunction

task automatic compare_val(input string name, input int got, input int exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        err_cnt++;
    end
endtask

// nine hi-res bytes are two words back to back, oldest sample first
task automatic rebuild_samples(input bit hi_res);
    logic [71:0] pair;
    rd_samples.delete();
    if (!hi_res) begin
        foreach (rd_bytes[i])
            rd_samples.push_back(int'(rd_bytes[i]));
    end else begin
        for (int i = 0; i + 9 <= rd_bytes.size(); i += 9) begin
            pair = '0;
            for (int b = 0; b < 9; b++)
                pair = {pair[63:0], rd_bytes[i + b]};
            for (int s = 5; s >= 0; s--)
                rd_samples.push_back(int'(pair[s*12 +: 12]));
        end
    end
endtask

function automatic int expect_val(input int idx, input bit hi_res);
    return hi_res ? sample_log[idx] : (sample_log[idx] >> 4);  // low-res keeps 8 msbs
endfunction

// first log index where the readback lines up at the given stride, -1 if none
function automatic int find_run(input int from_idx, input int stride, input bit hi_res);
    bit hit;
    for (int s = from_idx; s < sample_log.size(); s++) begin
        if (s + (rd_samples.size() - 1) * stride >= sample_log.size())
            break;
        hit = 1'b1;
        foreach (rd_samples[k])
            if (rd_samples[k] != expect_val(s + k * stride, hi_res))
                hit = 1'b0;
        if (hit)
            return s;
    end
    return -1;
endfunction

`endif

/* bench/tb_fifo_capture.sv */
module tb_fifo_capture
    import capture_pkg::*;
    import readout_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic         adc_sampleclk;
    logic         reset;
    sample_t      adc_data;
    logic         arm;
    logic         capture_go;
    capture_cfg_t cfg;
    read_mode_e   read_mode;
    logic         read_en;
    logic         capture_done;
    logic         fifo_empty;
    logic [7:0]   read_data;

    logic [31:0]  rng;
    int           cycle_cnt;
    int           limit;
    bit           limit_set;
    int           err_cnt;
    int           pass_cnt;
    int           fail_cnt;
    int           sample_log[$];   // one entry per driven cycle
    logic [7:0]   rd_bytes[$];
    int           rd_samples[$];
    string        test_name[6] = '{"sample count", "data order", "downsample",
                                   "presample", "low-res", "re-arm"};

    `include "capture_model.svh"

    fifo_capture_top #(.FAST_DEPTH(64), .SLOW_DEPTH(64)) dut (
        .reset(reset), .adc_sampleclk(adc_sampleclk), .adc_data_i(adc_data),
        .arm_i(arm), .capture_go_i(capture_go), .cfg_i(cfg), .read_mode_i(read_mode),
        .read_en_i(read_en), .capture_done_o(capture_done), .fifo_empty_o(fifo_empty),
        .read_data_o(read_data)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #20 adc_sampleclk = ~adc_sampleclk;
    end

    initial begin
        wait (limit_set);
        while (cycle_cnt < limit)
            @(negedge adc_sampleclk);
        $display("timeout: no result after %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

    function automatic int rand_range(input int lo, input int hi);
        rng = xorshift32(rng);
        return lo + int'(rng[15:0]) % (hi - lo + 1);
    endfunction

    // one falling edge, fresh adc sample logged with its cycle index
    task automatic tick();
        @(negedge adc_sampleclk);
        rng = xorshift32(rng);
        adc_data = rng[11:0];
        sample_log.push_back(int'(rng[11:0]));
        cycle_cnt++;
    endtask

    task automatic run_capture(input int ds, input int pre, input int max_s, input bit hi_res);
        int arm_idx;
        int go_idx;
        int target;
        int start;
        int n_pre;
        target = round_to_six(max_s);
        tick();
        cfg.presample   = count_t'(pre);
        cfg.max_samples = count_t'(max_s);
        cfg.downsample  = ds_count_t'(ds);
        read_mode = hi_res ? HIGH_RES : LOW_RES;
        tick();
        arm = 1'b1;
        arm_idx = cycle_cnt - 1;
        go_idx = arm_idx;
        if (pre != 0) begin
            repeat (pre * (ds + 1) + 20) tick();  // window full by now
            go_idx = cycle_cnt;
        end
        tick();
        capture_go = 1'b1;
        compare_val("capture_done_o", capture_done, 0);  // cleared by the arm
        while (!capture_done)
            tick();
        rd_bytes.delete();
        while (!fifo_empty) begin
            rd_bytes.push_back(read_data);
            read_en = 1'b1;
            tick();
        end
        read_en = 1'b0;
        compare_val("capture_done_o", capture_done, 1);  // held until the next arm
        arm = 1'b0;
        capture_go = 1'b0;
        rebuild_samples(hi_res);
        compare_val("read byte count", rd_bytes.size(), hi_res ? target * 3 / 2 : target);
        compare_val("read sample count", rd_samples.size(), target);
        start = find_run(arm_idx, ds + 1, hi_res);
        if (start < 0) begin
            $display("capture armed at cycle %0d: samples match no run of the input", arm_idx);
            err_cnt++;
        end else begin
            n_pre = 0;
            foreach (rd_samples[k])
                if (start + k * (ds + 1) <= go_idx)
                    n_pre++;
            compare_val("presample count", n_pre, pre);
        end
    endtask

    task automatic finish_test(input int tno, input int err_before);
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %0d %s: pass", tno, test_name[tno - 1]);
        end else begin
            fail_cnt++;
            $display("test %0d %s: fail, %0d errors", tno, test_name[tno - 1],
                     err_cnt - err_before);
        end
    endtask

    initial begin
        int err_before;
        int ds_q[7];
        int pre_q[7];
        int max_q[7];
        reset = 1'b1;
        adc_data = '0;
        arm = 1'b0;
        capture_go = 1'b0;
        cfg = '0;
        read_mode = HIGH_RES;
        read_en = 1'b0;
        rng = 32'd87;
        cycle_cnt = 0;
        limit = 0;
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        // entries 5 and 6 are the back-to-back pair
        for (int i = 0; i < 7; i++) begin
            ds_q[i]  = (i == 2 || i >= 5) ? rand_range(1, 3) : 0;
            pre_q[i] = (i == 3 || i >= 5) ? rand_range(6, 30) : 0;
            max_q[i] = rand_range(36, 180);
            limit += max_q[i] * (ds_q[i] + 1) + 2000;
        end
        limit_set = 1'b1;
        repeat (16) tick();
        reset = 1'b0;
        for (int t = 0; t < 6; t++) begin
            err_before = err_cnt;
            run_capture(ds_q[t], pre_q[t], max_q[t], t != 4);
            if (t == 5)
                run_capture(ds_q[6], pre_q[6], max_q[6], 1'b0);
            finish_test(t + 1, err_before);
        end
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+bench
common/capture_pkg.sv
common/readout_pkg.sv
hw/downsampler.sv
hw/sample_fifo.sv
capture/capture_fsm.sv
capture/sample_packer.sv
readout/byte_reader.sv
hw/fifo_capture_top.sv
bench/tb_fifo_capture.sv

/* run_sim.sh */
#!/bin/sh
# build and run the capture testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_fifo_capture -f verilog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fifo_capture > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
